// ==== Makefile ====
# Verilator build and run for the sample buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_rf_buffer
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= All tests passed!

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== capture/adc_capture.sv ====
`timescale 1ns/1ps
module adc_capture #(
	parameter int DEPTH_LOG2 = 8
) (
	input  logic                  clk_adc2,
	input  logic                  arst_n,
	input  logic                  start,
	input  logic [DEPTH_LOG2:0]   len,
	output logic                  busy,
	output logic                  done,
	input  logic                  adc_valid,
	input  stream_pkg::adc_word_t adc_data,
	output logic                  adc_ready,
	output logic                  ram_we,
	output logic [DEPTH_LOG2-1:0] ram_waddr,
	output stream_pkg::adc_word_t ram_wdata
);

	// words accepted so far in this run
	logic [DEPTH_LOG2:0] cnt;
	logic [DEPTH_LOG2:0] cnt_nxt;
	// run length latched at start
	logic [DEPTH_LOG2:0] len_q;
	logic                xfer;

	// source only sees ready inside the capture window
	assign adc_ready = busy;
	assign xfer      = adc_valid && busy;
	assign cnt_nxt   = cnt + 1'b1;

	// word k lands at address k
	assign ram_we    = xfer;
	assign ram_waddr = cnt[DEPTH_LOG2-1:0];
	assign ram_wdata = adc_data;

	always_ff @(posedge clk_adc2 or negedge arst_n) begin
		if (!arst_n) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			cnt   <= '0;
			len_q <= '0;
		end else begin
			// done is a single-cycle pulse
			done <= 1'b0;
			if (start && !busy && len != '0) begin
				busy  <= 1'b1;
				cnt   <= '0;
				len_q <= len;
			end else if (xfer) begin
				cnt <= cnt_nxt;
				// close the window on the final transfer edge
				if (cnt_nxt == len_q) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== common/lb_pkg.sv ====
package lb_pkg;

	// host request, one write and one read channel per cycle
	typedef struct packed {
		logic        wren;
		logic [11:0] waddr;
		logic [31:0] wdata;
		logic        rden;
		logic [11:0] raddr;
	} lb_req_t;

	// read response, rdata only meaningful with rvalid
	typedef struct packed {
		logic        rvalid;
		logic [31:0] rdata;
	} lb_rsp_t;

	// region field position in the 12-bit address
	localparam int REGION_MSB = 11;
	localparam int REGION_LSB = 10;

	localparam logic [1:0] REGION_REGS = 2'd0;
	// capture ram, read side
	localparam logic [1:0] REGION_CAP  = 2'd1;
	// playback ram, write side
	localparam logic [1:0] REGION_PLAY = 2'd2;

	// register word offsets inside REGION_REGS
	localparam logic [9:0] REG_CTRL     = 10'd0;
	localparam logic [9:0] REG_STATUS   = 10'd1;
	localparam logic [9:0] REG_CAP_LEN  = 10'd2;
	localparam logic [9:0] REG_PLAY_LEN = 10'd3;

	// ctrl strobe bits
	localparam int CTRL_CAP_START  = 0;
	localparam int CTRL_PLAY_START = 1;

	// status bits
	localparam int STAT_CAP_BUSY  = 0;
	localparam int STAT_CAP_DONE  = 1;
	localparam int STAT_PLAY_BUSY = 2;
	localparam int STAT_PLAY_DONE = 3;

endpackage

// ==== common/stream_pkg.sv ====
package stream_pkg;

	// one signed adc sample
	typedef logic signed [15:0] adc_sample_t;

	// sample 1 sits in the upper half of the host word
	typedef struct packed {
		adc_sample_t s1;
		adc_sample_t s0;
	} adc_word_t;

	// one dac code, 12 bits
	typedef logic [11:0] dac_code_t;

	// low 24 bits of host write data
	typedef struct packed {
		dac_code_t c1;
		dac_code_t c0;
	} dac_word_t;

	// stream beat, last marks the final word of a run
	typedef struct packed {
		dac_word_t data;
		logic      last;
	} dac_beat_t;

endpackage

// ==== flist.f ====
common/lb_pkg.sv
common/stream_pkg.sv
src/sample_ram.sv
capture/adc_capture.sv
playback/dac_playback.sv
src/buffer_ctrl.sv
src/rf_buffer_top.sv
tests/rf_buffer_chk.sv
tests/tb_rf_buffer.sv

// ==== playback/dac_playback.sv ====
`timescale 1ns/1ps
module dac_playback #(
	parameter int DEPTH_LOG2 = 8
) (
	input  logic                  clk_adc2,
	input  logic                  arst_n,
	input  logic                  start,
	input  logic [DEPTH_LOG2:0]   len,
	output logic                  busy,
	output logic                  done,
	output logic                  ram_re,
	output logic [DEPTH_LOG2-1:0] ram_raddr,
	input  stream_pkg::dac_word_t ram_rdata,
	output logic                  dac_valid,
	output stream_pkg::dac_beat_t dac_beat,
	input  logic                  dac_ready
);

	// next ram address to read
	logic [DEPTH_LOG2:0] rd_addr;
	logic [DEPTH_LOG2:0] len_q;
	// read issued last cycle, data shows up on ram_rdata now
	logic                rd_pend;
	logic                pend_last;

	// two-entry output buffer
	stream_pkg::dac_beat_t fifo [2];
	logic                  wr_ptr;
	logic                  rd_ptr;
	logic [1:0]            cnt;
	// occupancy after this cycle's push and pop
	logic [2:0]            fill;

	logic push;
	logic pop;
	logic issue;

	assign push = rd_pend;
	assign pop  = dac_valid && dac_ready;
	assign fill = 3'(cnt) + 3'(rd_pend) - 3'(pop);

	// only read when the returning word is sure to find a free entry
	assign issue = busy && (rd_addr != len_q) && (fill <= 3'd1);

	assign ram_re    = issue;
	assign ram_raddr = rd_addr[DEPTH_LOG2-1:0];

	// head entry stays put until popped
	assign dac_valid = (cnt != 2'd0);
	assign dac_beat  = fifo[rd_ptr];

	always_ff @(posedge clk_adc2 or negedge arst_n) begin
		if (!arst_n) begin
			busy      <= 1'b0;
			done      <= 1'b0;
			rd_addr   <= '0;
			len_q     <= '0;
			rd_pend   <= 1'b0;
			pend_last <= 1'b0;
			wr_ptr    <= 1'b0;
			rd_ptr    <= 1'b0;
			cnt       <= 2'd0;
		end else begin
			done    <= 1'b0;
			rd_pend <= issue;
			if (start && !busy && len != '0) begin
				busy    <= 1'b1;
				rd_addr <= '0;
				len_q   <= len;
			end else if (issue) begin
				// tag the word read from the final address
				pend_last <= (rd_addr == len_q - 1'b1);
				rd_addr   <= rd_addr + 1'b1;
			end
			if (push) begin
				wr_ptr <= ~wr_ptr;
			end
			if (pop) begin
				rd_ptr <= ~rd_ptr;
			end
			cnt <= cnt + 2'(push) - 2'(pop);
			// run ends on the edge the last beat leaves
			if (pop && dac_beat.last) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// buffer payload
	always_ff @(posedge clk_adc2) begin
		if (push) begin
			fifo[wr_ptr] <= '{data: ram_rdata, last: pend_last};
		end
	end

endmodule

// ==== src/buffer_ctrl.sv ====
`timescale 1ns/1ps
module buffer_ctrl #(
	parameter int DEPTH_LOG2 = 8
) (
	input  logic                  clk_adc2,
	input  logic                  arst_n,
	input  lb_pkg::lb_req_t       lb_req,
	output lb_pkg::lb_rsp_t       lb_rsp,
	output logic                  cap_start,
	output logic [DEPTH_LOG2:0]   cap_len,
	input  logic                  cap_busy,
	input  logic                  cap_done,
	output logic                  play_start,
	output logic [DEPTH_LOG2:0]   play_len,
	input  logic                  play_busy,
	input  logic                  play_done,
	output logic                  cap_re,
	output logic [DEPTH_LOG2-1:0] cap_raddr,
	input  stream_pkg::adc_word_t cap_rdata,
	output logic                  play_we,
	output logic [DEPTH_LOG2-1:0] play_waddr,
	output stream_pkg::dac_word_t play_wdata
);

	localparam logic [31:0] DEPTH = 32'(2 ** DEPTH_LOG2);

	logic [1:0]  wr_region;
	logic [1:0]  rd_region;
	logic [9:0]  wr_idx;
	logic [9:0]  rd_idx;
	logic        wr_reg;
	logic        wr_ctrl;
	logic        cap_go;
	logic        play_go;
	logic        cap_done_q;
	logic        play_done_q;
	logic [31:0] reg_rdata;
	// read pipe, stage one
	logic        rd_vld_q;
	logic        rd_cap_q;
	logic [31:0] reg_rdata_q;
	// read pipe, output stage
	logic        rsp_valid_q;
	logic [31:0] rsp_data_q;

	// lengths above the ram depth saturate
	function automatic logic [DEPTH_LOG2:0] clamp_len(input logic [31:0] v);
		logic [31:0] c;
		c = (v > DEPTH) ? DEPTH : v;
		return c[DEPTH_LOG2:0];
	endfunction

	// address decode
	assign wr_region = lb_req.waddr[lb_pkg::REGION_MSB:lb_pkg::REGION_LSB];
	assign rd_region = lb_req.raddr[lb_pkg::REGION_MSB:lb_pkg::REGION_LSB];
	assign wr_idx    = lb_req.waddr[lb_pkg::REGION_LSB-1:0];
	assign rd_idx    = lb_req.raddr[lb_pkg::REGION_LSB-1:0];
	assign wr_reg    = lb_req.wren && (wr_region == lb_pkg::REGION_REGS);
	assign wr_ctrl   = wr_reg && (wr_idx == lb_pkg::REG_CTRL);

	// a pending start pulse counts as busy too
	assign cap_go = wr_ctrl && lb_req.wdata[lb_pkg::CTRL_CAP_START]
		&& !cap_busy && !cap_start && (cap_len != '0);
	assign play_go = wr_ctrl && lb_req.wdata[lb_pkg::CTRL_PLAY_START]
		&& !play_busy && !play_start && (play_len != '0);

	// host writes straight into the playback ram
	assign play_we    = lb_req.wren && (wr_region == lb_pkg::REGION_PLAY);
	assign play_waddr = lb_req.waddr[DEPTH_LOG2-1:0];
	assign play_wdata = stream_pkg::dac_word_t'(lb_req.wdata[23:0]);

	// capture ram read goes out in the rden cycle
	assign cap_re    = lb_req.rden && (rd_region == lb_pkg::REGION_CAP);
	assign cap_raddr = lb_req.raddr[DEPTH_LOG2-1:0];

	// register file and run control
	always_ff @(posedge clk_adc2 or negedge arst_n) begin
		if (!arst_n) begin
			cap_len     <= '0;
			play_len    <= '0;
			cap_start   <= 1'b0;
			play_start  <= 1'b0;
			cap_done_q  <= 1'b0;
			play_done_q <= 1'b0;
		end else begin
			cap_start  <= cap_go;
			play_start <= play_go;
			if (wr_reg && wr_idx == lb_pkg::REG_CAP_LEN) begin
				cap_len <= clamp_len(lb_req.wdata);
			end
			if (wr_reg && wr_idx == lb_pkg::REG_PLAY_LEN) begin
				play_len <= clamp_len(lb_req.wdata);
			end
			// sticky done, cleared only by an accepted start
			if (cap_go) begin
				cap_done_q <= 1'b0;
			end else if (cap_done) begin
				cap_done_q <= 1'b1;
			end
			if (play_go) begin
				play_done_q <= 1'b0;
			end else if (play_done) begin
				play_done_q <= 1'b1;
			end
		end
	end

	// register read mux, ctrl and unmapped offsets read 0
	always_comb begin
		reg_rdata = '0;
		if (rd_region == lb_pkg::REGION_REGS) begin
			case (rd_idx)
				lb_pkg::REG_STATUS: begin
					reg_rdata[lb_pkg::STAT_CAP_BUSY]  = cap_busy;
					reg_rdata[lb_pkg::STAT_CAP_DONE]  = cap_done_q;
					reg_rdata[lb_pkg::STAT_PLAY_BUSY] = play_busy;
					reg_rdata[lb_pkg::STAT_PLAY_DONE] = play_done_q;
				end
				lb_pkg::REG_CAP_LEN:  reg_rdata[DEPTH_LOG2:0] = cap_len;
				lb_pkg::REG_PLAY_LEN: reg_rdata[DEPTH_LOG2:0] = play_len;
				default: reg_rdata = '0;
			endcase
		end
	end

	// valid and region tag ride along with the ram access
	always_ff @(posedge clk_adc2 or negedge arst_n) begin
		if (!arst_n) begin
			rd_vld_q    <= 1'b0;
			rd_cap_q    <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			rd_vld_q    <= lb_req.rden;
			rd_cap_q    <= (rd_region == lb_pkg::REGION_CAP);
			rsp_valid_q <= rd_vld_q;
		end
	end

	// data side of the read pipe
	always_ff @(posedge clk_adc2) begin
		reg_rdata_q <= reg_rdata;
		rsp_data_q  <= rd_cap_q ? 32'(cap_rdata) : reg_rdata_q;
	end

	assign lb_rsp.rvalid = rsp_valid_q;
	assign lb_rsp.rdata  = rsp_data_q;

endmodule

// ==== src/rf_buffer_top.sv ====
`timescale 1ns/1ps
module rf_buffer_top #(
	parameter int DEPTH_LOG2 = 8
) (
	input  logic                  clk_adc2,
	input  logic                  arst_n,
	input  lb_pkg::lb_req_t       lb_req,
	output lb_pkg::lb_rsp_t       lb_rsp,
	input  logic                  adc_valid,
	input  stream_pkg::adc_word_t adc_data,
	output logic                  adc_ready,
	output logic                  dac_valid,
	output stream_pkg::dac_beat_t dac_beat,
	input  logic                  dac_ready
);

	// run control
	logic                  cap_start;
	logic [DEPTH_LOG2:0]   cap_len;
	logic                  cap_busy;
	logic                  cap_done;
	logic                  play_start;
	logic [DEPTH_LOG2:0]   play_len;
	logic                  play_busy;
	logic                  play_done;

	// capture ram ports
	logic                  cap_we;
	logic [DEPTH_LOG2-1:0] cap_waddr;
	stream_pkg::adc_word_t cap_wdata;
	logic                  cap_re;
	logic [DEPTH_LOG2-1:0] cap_raddr;
	stream_pkg::adc_word_t cap_rdata;

	// playback ram ports
	logic                  play_we;
	logic [DEPTH_LOG2-1:0] play_waddr;
	stream_pkg::dac_word_t play_wdata;
	logic                  play_re;
	logic [DEPTH_LOG2-1:0] play_raddr;
	stream_pkg::dac_word_t play_rdata;

	buffer_ctrl #(.DEPTH_LOG2(DEPTH_LOG2)) u_ctrl (
		.clk_adc2   (clk_adc2),
		.arst_n     (arst_n),
		.lb_req     (lb_req),
		.lb_rsp     (lb_rsp),
		.cap_start  (cap_start),
		.cap_len    (cap_len),
		.cap_busy   (cap_busy),
		.cap_done   (cap_done),
		.play_start (play_start),
		.play_len   (play_len),
		.play_busy  (play_busy),
		.play_done  (play_done),
		.cap_re     (cap_re),
		.cap_raddr  (cap_raddr),
		.cap_rdata  (cap_rdata),
		.play_we    (play_we),
		.play_waddr (play_waddr),
		.play_wdata (play_wdata)
	);

	adc_capture #(.DEPTH_LOG2(DEPTH_LOG2)) u_capture (
		.clk_adc2  (clk_adc2),
		.arst_n    (arst_n),
		.start     (cap_start),
		.len       (cap_len),
		.busy      (cap_busy),
		.done      (cap_done),
		.adc_valid (adc_valid),
		.adc_data  (adc_data),
		.adc_ready (adc_ready),
		.ram_we    (cap_we),
		.ram_waddr (cap_waddr),
		.ram_wdata (cap_wdata)
	);

	// capture side, 32-bit sample pairs
	sample_ram #(
		.DEPTH_LOG2 (DEPTH_LOG2),
		.payload_t  (stream_pkg::adc_word_t)
	) u_cap_ram (
		.clk_adc2 (clk_adc2),
		.we       (cap_we),
		.waddr    (cap_waddr),
		.wdata    (cap_wdata),
		.re       (cap_re),
		.raddr    (cap_raddr),
		.rdata    (cap_rdata)
	);

	// playback side, 24-bit code pairs
	sample_ram #(
		.DEPTH_LOG2 (DEPTH_LOG2),
		.payload_t  (stream_pkg::dac_word_t)
	) u_play_ram (
		.clk_adc2 (clk_adc2),
		.we       (play_we),
		.waddr    (play_waddr),
		.wdata    (play_wdata),
		.re       (play_re),
		.raddr    (play_raddr),
		.rdata    (play_rdata)
	);

	dac_playback #(.DEPTH_LOG2(DEPTH_LOG2)) u_playback (
		.clk_adc2  (clk_adc2),
		.arst_n    (arst_n),
		.start     (play_start),
		.len       (play_len),
		.busy      (play_busy),
		.done      (play_done),
		.ram_re    (play_re),
		.ram_raddr (play_raddr),
		.ram_rdata (play_rdata),
		.dac_valid (dac_valid),
		.dac_beat  (dac_beat),
		.dac_ready (dac_ready)
	);

endmodule

// ==== src/sample_ram.sv ====
`timescale 1ns/1ps
module sample_ram #(
	parameter int DEPTH_LOG2 = 8,
	parameter type payload_t = logic [31:0]
) (
	input  logic                  clk_adc2,
	input  logic                  we,
	input  logic [DEPTH_LOG2-1:0] waddr,
	input  payload_t              wdata,
	input  logic                  re,
	input  logic [DEPTH_LOG2-1:0] raddr,
	output payload_t              rdata
);

	// plain array, maps onto block ram
	payload_t mem [2 ** DEPTH_LOG2];

	// write port
	always_ff @(posedge clk_adc2) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// registered read, output holds between reads
	always_ff @(posedge clk_adc2) begin
		if (re) begin
			rdata <= mem[raddr];
		end
	end

endmodule

// ==== tests/rf_buffer_chk.sv ====
`timescale 1ns/1ps
module rf_buffer_chk (
	input logic                  clk_adc2,
	input logic                  arst_n,
	input lb_pkg::lb_req_t       lb_req,
	input lb_pkg::lb_rsp_t       lb_rsp,
	input logic                  adc_ready,
	input logic                  cap_start,
	input logic                  cap_done,
	input logic                  play_start,
	input logic                  dac_valid,
	input stream_pkg::dac_beat_t dac_beat,
	input logic                  dac_ready
);

	// set by the first playback start after reset
	logic play_seen;
	// open from the capture start pulse until the done pulse
	logic cap_open;

	always_ff @(posedge clk_adc2 or negedge arst_n) begin
		if (!arst_n) begin
			play_seen <= 1'b0;
		end else if (play_start) begin
			play_seen <= 1'b1;
		end
	end

	always_ff @(posedge clk_adc2 or negedge arst_n) begin
		if (!arst_n) begin
			cap_open <= 1'b0;
		end else if (cap_start) begin
			cap_open <= 1'b1;
		end else if (cap_done) begin
			cap_open <= 1'b0;
		end
	end

	// stalled beat holds its payload
	a_beat_stable: assert property (@(posedge clk_adc2) disable iff (!arst_n)
		dac_valid && !dac_ready |=> dac_valid && $stable(dac_beat))
		else $error("dac beat changed or dropped while stalled");

	// fixed two-cycle read latency in both directions
	a_read_latency: assert property (@(posedge clk_adc2) disable iff (!arst_n)
		lb_rsp.rvalid == $past(lb_req.rden, 2))
		else $error("rvalid not exactly two cycles after rden");

	// capture window only
	a_ready_in_run: assert property (@(posedge clk_adc2) disable iff (!arst_n)
		!cap_open |-> !adc_ready)
		else $error("adc_ready high outside a capture run");

	// quiet dac stream until a playback is launched
	a_no_early_beat: assert property (@(posedge clk_adc2) disable iff (!arst_n)
		!play_seen |-> !dac_valid)
		else $error("dac_valid before any playback start");

endmodule

bind rf_buffer_top rf_buffer_chk u_chk (
	.clk_adc2   (clk_adc2),
	.arst_n     (arst_n),
	.lb_req     (lb_req),
	.lb_rsp     (lb_rsp),
	.adc_ready  (adc_ready),
	.cap_start  (cap_start),
	.cap_done   (cap_done),
	.play_start (play_start),
	.dac_valid  (dac_valid),
	.dac_beat   (dac_beat),
	.dac_ready  (dac_ready)
);

// ==== tests/tb_rf_buffer.sv ====
`timescale 1ns/1ps
module tb_rf_buffer;

	localparam int DEPTH_LOG2 = 6;
	localparam int DEPTH      = 2 ** DEPTH_LOG2;
	// words moved over all tests, a few depth-sized blocks at most
	localparam int PLAN_WORDS = 16 + 9 * DEPTH;

	localparam logic [11:0] ADDR_CTRL     = {lb_pkg::REGION_REGS, lb_pkg::REG_CTRL};
	localparam logic [11:0] ADDR_STATUS   = {lb_pkg::REGION_REGS, lb_pkg::REG_STATUS};
	localparam logic [11:0] ADDR_CAP_LEN  = {lb_pkg::REGION_REGS, lb_pkg::REG_CAP_LEN};
	localparam logic [11:0] ADDR_PLAY_LEN = {lb_pkg::REGION_REGS, lb_pkg::REG_PLAY_LEN};

	logic                  clk_adc2;
	logic                  arst_n;
	lb_pkg::lb_req_t       lb_req;
	lb_pkg::lb_rsp_t       lb_rsp;
	logic                  adc_valid;
	stream_pkg::adc_word_t adc_data;
	logic                  adc_ready;
	logic                  dac_valid;
	stream_pkg::dac_beat_t dac_beat;
	logic                  dac_ready;

	int   seed       = 15;
	// separate stream for the sink, independent of process order
	int   ready_seed = 15;
	logic ready_on   = 1'b0;
	int   failed     = 0;

	// reference model
	logic [31:0] cap_mem [DEPTH];
	logic [23:0] play_mem [DEPTH];
	logic        cap_done_m  = 1'b0;
	logic        play_done_m = 1'b0;

	rf_buffer_top #(.DEPTH_LOG2(DEPTH_LOG2)) UUT (
		.clk_adc2  (clk_adc2),
		.arst_n    (arst_n),
		.lb_req    (lb_req),
		.lb_rsp    (lb_rsp),
		.adc_valid (adc_valid),
		.adc_data  (adc_data),
		.adc_ready (adc_ready),
		.dac_valid (dac_valid),
		.dac_beat  (dac_beat),
		.dac_ready (dac_ready)
	);

	response_checker u_mon (
		.clk_adc2  (clk_adc2),
		.arst_n    (arst_n),
		.lb_req    (lb_req),
		.lb_rsp    (lb_rsp),
		.adc_valid (adc_valid),
		.adc_ready (adc_ready),
		.dac_valid (dac_valid),
		.dac_beat  (dac_beat),
		.dac_ready (dac_ready)
	);

	initial begin
		clk_adc2 = 1'b0;
		forever #20 clk_adc2 = ~clk_adc2;
	end

	// lengths saturate at the ram depth
	function automatic int clamp_depth(input logic [31:0] v);
		if (v > 32'(DEPTH)) begin
			return DEPTH;
		end
		return int'(v);
	endfunction

	function automatic logic [31:0] status_word(input logic cb, input logic cd,
		input logic pb, input logic pd);
		return {28'd0, pd, pb, cd, cb};
	endfunction

	// inputs change just after the rising edge
	task automatic tick();
		@(posedge clk_adc2);
		#2;
	endtask

	task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
		lb_req.wren  = 1'b1;
		lb_req.waddr = addr;
		lb_req.wdata = data;
		tick();
		lb_req.wren = 1'b0;
	endtask

	task automatic bus_read(input logic [11:0] addr, input logic [31:0] exp);
		lb_req.rden  = 1'b1;
		lb_req.raddr = addr;
		u_mon.expect_read(exp);
		tick();
		lb_req.rden = 1'b0;
	endtask

	// responses come back two cycles after the request
	task automatic drain_reads();
		repeat (3) tick();
	endtask

	// offer n words with random gaps, then one word that must be refused
	task automatic offer_adc(input int n);
		logic hs;
		int   gap;
		for (int i = 0; i < n; i++) begin
			adc_data  = $random(seed);
			adc_valid = 1'b1;
			hs        = 1'b0;
			while (!hs) begin
				// mid-cycle, handshake for the coming edge
				@(negedge clk_adc2);
				hs = adc_ready;
				tick();
			end
			cap_mem[i] = adc_data;
			adc_valid  = 1'b0;
			gap = $random(seed) & 3;
			repeat (gap) tick();
		end
		adc_data  = $random(seed);
		adc_valid = 1'b1;
		repeat (4) tick();
		adc_valid = 1'b0;
	endtask

	task automatic load_playback(input int n);
		logic [31:0] w;
		for (int i = 0; i < n; i++) begin
			w           = $random(seed);
			play_mem[i] = w[23:0];
			bus_write({lb_pkg::REGION_PLAY, 10'(i)}, w);
		end
	endtask

	task automatic expect_stream(input int n);
		for (int i = 0; i < n; i++) begin
			u_mon.expect_beat(play_mem[i], i == n - 1);
		end
	endtask

	task automatic wait_stream();
		while (u_mon.pending_beats() != 0) begin
			tick();
		end
		tick();
	endtask

	task automatic report_test(input string name, input int err0);
		u_mon.check_drained();
		if (u_mon.error_count == err0) begin
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: FAILED with %0d errors", name, u_mon.error_count - err0);
		end
	endtask

	// random sink back-pressure
	initial begin
		logic [31:0] r;
		dac_ready = 1'b0;
		forever begin
			tick();
			r         = $random(ready_seed);
			dac_ready = ready_on && r[0];
		end
	end

	initial begin
		repeat (PLAN_WORDS * 20) @(posedge clk_adc2);
		$display("timeout: run did not finish within %0d cycles", PLAN_WORDS * 20);
		$display("Test failures found");
		$finish;
	end

	initial begin
		int          n;
		int          err0;
		logic [31:0] v;
		lb_req    = '0;
		adc_valid = 1'b0;
		adc_data  = '0;
		arst_n    = 1'b0;
		repeat (4) @(posedge clk_adc2);
		#2;
		arst_n = 1'b1;
		tick();

		// lengths, ctrl and status readback, back-to-back reads
		err0 = u_mon.error_count;
		v = $random(seed) & 127;
		bus_write(ADDR_CAP_LEN, v);
		n = clamp_depth(v);
		v = $random(seed) & 127;
		bus_write(ADDR_PLAY_LEN, v);
		bus_read(ADDR_CTRL, 32'd0);
		bus_read(ADDR_CAP_LEN, 32'(n));
		bus_read(ADDR_PLAY_LEN, 32'(clamp_depth(v)));
		bus_read(ADDR_STATUS, 32'd0);
		drain_reads();
		report_test("register access", err0);

		// capture run with gaps and a refused extra word
		err0 = u_mon.error_count;
		n = 1 + ($random(seed) & 63);
		bus_write(ADDR_CAP_LEN, n);
		u_mon.allow_capture(n);
		bus_write(ADDR_CTRL, 32'h1);
		tick();
		bus_read(ADDR_STATUS, status_word(1'b1, 1'b0, 1'b0, play_done_m));
		offer_adc(n);
		cap_done_m = 1'b1;
		bus_read(ADDR_STATUS, status_word(1'b0, cap_done_m, 1'b0, play_done_m));
		for (int k = 0; k < n; k++) begin
			bus_read({lb_pkg::REGION_CAP, 10'(k)}, cap_mem[k]);
		end
		drain_reads();
		report_test("capture", err0);

		// playback against random sink stalls
		err0 = u_mon.error_count;
		n = 1 + ($random(seed) & 63);
		load_playback(n);
		bus_write(ADDR_PLAY_LEN, n);
		expect_stream(n);
		ready_on = 1'b1;
		bus_write(ADDR_CTRL, 32'h2);
		wait_stream();
		play_done_m = 1'b1;
		bus_read(ADDR_STATUS, status_word(1'b0, cap_done_m, 1'b0, play_done_m));
		drain_reads();
		report_test("playback", err0);

		// second start during a run, then a zero-length start
		err0 = u_mon.error_count;
		n = 16 + ($random(seed) & 31);
		load_playback(n);
		bus_write(ADDR_PLAY_LEN, n);
		expect_stream(n);
		ready_on = 1'b0;
		bus_write(ADDR_CTRL, 32'h2);
		repeat (3) tick();
		bus_write(ADDR_CTRL, 32'h2);
		ready_on = 1'b1;
		wait_stream();
		repeat (4) tick();
		bus_read(ADDR_STATUS, status_word(1'b0, cap_done_m, 1'b0, play_done_m));
		bus_write(ADDR_PLAY_LEN, 32'd0);
		bus_write(ADDR_CTRL, 32'h2);
		tick();
		bus_read(ADDR_STATUS, status_word(1'b0, cap_done_m, 1'b0, play_done_m));
		bus_read(ADDR_PLAY_LEN, 32'd0);
		drain_reads();
		report_test("ignored starts", err0);

		// oversized lengths, capture and playback side by side
		err0 = u_mon.error_count;
		bus_write(ADDR_CAP_LEN, DEPTH + 1 + ($random(seed) & 255));
		bus_write(ADDR_PLAY_LEN, $random(seed) | 32'h100);
		load_playback(DEPTH);
		expect_stream(DEPTH);
		u_mon.allow_capture(DEPTH);
		bus_read(ADDR_CAP_LEN, 32'(DEPTH));
		bus_read(ADDR_PLAY_LEN, 32'(DEPTH));
		bus_write(ADDR_CTRL, 32'h3);
		fork
			offer_adc(DEPTH);
			wait_stream();
		join
		bus_read(ADDR_STATUS, status_word(1'b0, 1'b1, 1'b0, 1'b1));
		for (int k = 0; k < DEPTH; k++) begin
			bus_read({lb_pkg::REGION_CAP, 10'(k)}, cap_mem[k]);
		end
		drain_reads();
		report_test("full depth overlap", err0);

		$display("tests run 5, failed %0d, errors %0d", failed, u_mon.error_count);
		if (failed == 0 && u_mon.error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// compares bus responses and dac beats with queued expectations
module response_checker (
	input logic                  clk_adc2,
	input logic                  arst_n,
	input lb_pkg::lb_req_t       lb_req,
	input lb_pkg::lb_rsp_t       lb_rsp,
	input logic                  adc_valid,
	input logic                  adc_ready,
	input logic                  dac_valid,
	input stream_pkg::dac_beat_t dac_beat,
	input logic                  dac_ready
);

	int                    error_count = 0;
	// adc transfers still allowed
	int                    cap_allow   = 0;
	int                    beat_idx    = 0;
	logic [1:0]            rden_hist   = 2'b00;
	logic [31:0]           read_q [$];
	stream_pkg::dac_beat_t beat_q [$];

	task automatic expect_read(input logic [31:0] v);
		read_q.push_back(v);
	endtask

	task automatic expect_beat(input logic [23:0] w, input logic last);
		stream_pkg::dac_beat_t b;
		b.data = w;
		b.last = last;
		beat_q.push_back(b);
	endtask

	task automatic allow_capture(input int n);
		cap_allow += n;
	endtask

	function automatic int pending_beats();
		return beat_q.size();
	endfunction

	task automatic check_drained();
		if (read_q.size() != 0 || beat_q.size() != 0) begin
			$display("missing responses: %0d reads and %0d dac beats never arrived",
				read_q.size(), beat_q.size());
			error_count++;
			read_q.delete();
			beat_q.delete();
		end
		beat_idx = 0;
	endtask

	// mid-cycle sampling, everything settled here
	always @(negedge clk_adc2) begin
		logic [31:0]           exp_data;
		stream_pkg::dac_beat_t exp_beat;
		if (!arst_n) begin
			rden_hist = 2'b00;
		end else begin
			if (lb_rsp.rvalid != rden_hist[1]) begin
				$display("Error at %0t: rvalid %0b, read issued two cycles back %0b",
					$time, lb_rsp.rvalid, rden_hist[1]);
				error_count++;
			end
			rden_hist = {rden_hist[0], lb_req.rden};
			if (lb_rsp.rvalid) begin
				if (read_q.size() == 0) begin
					$display("Error at %0t: read response with no read pending", $time);
					error_count++;
				end else begin
					exp_data = read_q.pop_front();
					if (lb_rsp.rdata !== exp_data) begin
						$display("Error at %0t: rdata 0x%08h, expected 0x%08h",
							$time, lb_rsp.rdata, exp_data);
						error_count++;
					end
				end
			end
			if (adc_valid && adc_ready) begin
				if (cap_allow == 0) begin
					$display("Error at %0t: adc word accepted outside a capture run", $time);
					error_count++;
				end else begin
					cap_allow--;
				end
			end
			if (dac_valid && dac_ready) begin
				if (beat_q.size() == 0) begin
					$display("Error at %0t: dac beat with none expected", $time);
					error_count++;
				end else begin
					exp_beat = beat_q.pop_front();
					if (dac_beat !== exp_beat) begin
						$display("Error at %0t: beat %0d is 0x%06h last %0b, expected 0x%06h last %0b",
							$time, beat_idx, dac_beat.data, dac_beat.last,
							exp_beat.data, exp_beat.last);
						error_count++;
					end
					beat_idx++;
				end
			end
		end
	end

endmodule
